/* design/regwin_pkg.sv */
// Register window shared definitions

package regwin_pkg;

	// register width
	localparam int DATA_W = 32;

	// visible register number, r0 to r31
	localparam int RNUM_W = 5;

	// r0-r7, shared by every window
	localparam int NUM_GLOBALS = 8;

	// new registers each window adds (locals plus outs)
	// the ins come from the next window's outs
	localparam int WIN_STRIDE = 16;

	// one register access as issued by a client
	typedef struct packed {
		// 1 = write, 0 = read
		logic rw;
		// visible register in the current window
		logic [RNUM_W-1:0] r_num;
		// write data, ignored on reads
		logic [DATA_W-1:0] wdata;
	} reg_access_t;

	// physical register count for a given number of windows
	// globals plus 16 per window, 72 for four windows
	function automatic int phys_count(int num_windows);
		return NUM_GLOBALS + WIN_STRIDE * num_windows;
	endfunction

endpackage

/* design/window_decoder.sv */
// Window register decoder

module window_decoder #(
	parameter int NUM_WINDOWS = 4,
	localparam int CWP_W = $clog2(NUM_WINDOWS),
	localparam int PHYS = regwin_pkg::phys_count(NUM_WINDOWS),
	localparam int IDX_W = $clog2(PHYS)
) (
	input logic [CWP_W-1:0] cwp,
	input logic [regwin_pkg::RNUM_W-1:0] r_num,
	output logic [IDX_W-1:0] phys_idx
);

	import regwin_pkg::*;

	// windowed part of the store, everything above the globals
	localparam int WIN_SPAN = WIN_STRIDE * NUM_WINDOWS;

	// first windowed register of the current window
	logic [IDX_W-1:0] win_base;
	// offset into the windowed part before wrapping
	logic [IDX_W-1:0] win_off;
	// offset after wrapping at the last window
	logic [IDX_W-1:0] win_wrap;
	logic is_global;

	// r0-r7 bypass the window logic
	assign is_global = (r_num < RNUM_W'(NUM_GLOBALS));

	// 16 registers per window step
	assign win_base = IDX_W'(WIN_STRIDE) * IDX_W'(cwp);

	// r8 is offset 0 of the window
	// only meaningful when r_num is not a global
	assign win_off = win_base + IDX_W'(r_num) - IDX_W'(NUM_GLOBALS);

	// max offset is 16*(n-1)+23, so one subtract is enough
	// ins of the last window land on the outs of window 0
	assign win_wrap = (win_off >= IDX_W'(WIN_SPAN)) ? win_off - IDX_W'(WIN_SPAN) : win_off;

	always_comb begin
		if (is_global) begin
			phys_idx = IDX_W'(r_num);
		end else begin
			// skip over the globals
			phys_idx = IDX_W'(NUM_GLOBALS) + win_wrap;
		end
	end

endmodule

/* design/register_file.sv */
// Windowed physical register store

module register_file #(
	parameter int NUM_WINDOWS = 4,
	localparam int CWP_W = $clog2(NUM_WINDOWS),
	localparam int PHYS = regwin_pkg::phys_count(NUM_WINDOWS),
	localparam int IDX_W = $clog2(PHYS)
) (
	input logic Clk,
	input logic rst_n,
	input logic gnt_valid,
	input regwin_pkg::reg_access_t gnt_acc,
	input logic [CWP_W-1:0] cwp,
	output logic rd_valid,
	output logic [regwin_pkg::DATA_W-1:0] rd_data
);

	import regwin_pkg::*;

	// globals first, then 16 per window
	logic [DATA_W-1:0] mem [PHYS];

	// decoded physical index of the granted access
	logic [IDX_W-1:0] idx;

	// write strobe for the array
	logic wr_en;

	// read strobe for the output register
	logic rd_en;

	// visible number to physical slot, using the grant-cycle cwp
	window_decoder #(
		.NUM_WINDOWS(NUM_WINDOWS)
	) u_window_decoder (
		.cwp(cwp),
		.r_num(gnt_acc.r_num),
		.phys_idx(idx)
	);

	// r0 lives at index 0 and never takes a write
	assign wr_en = gnt_valid && gnt_acc.rw && (idx != '0);

	assign rd_en = gnt_valid && !gnt_acc.rw;

	// register array
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			// every register starts at zero
			for (int i = 0; i < PHYS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[idx] <= gnt_acc.wdata;
		end
	end

	// registered read port
	// mem[0] stays zero, so r0 reads back as 0
	always_ff @(posedge Clk) begin
		if (rd_en) begin
			rd_data <= mem[idx];
		end
	end

	// completion strobe, one cycle after any grant
	// writes complete here as well as reads
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= gnt_valid;
		end
	end

endmodule

/* design/cwp_control.sv */
// Window pointer and invalid mask

module cwp_control #(
	parameter int NUM_WINDOWS = 4,
	localparam int CWP_W = $clog2(NUM_WINDOWS)
) (
	input logic Clk,
	input logic rst_n,
	input logic save,
	input logic restore,
	input logic wim_load,
	input logic [NUM_WINDOWS-1:0] wim_data,
	output logic [CWP_W-1:0] cwp,
	output logic overflow,
	output logic underflow
);

	// highest window number
	localparam logic [CWP_W-1:0] LAST_WIN = CWP_W'(NUM_WINDOWS - 1);

	// window invalid mask, one bit per window
	logic [NUM_WINDOWS-1:0] wim;

	// neighbour windows of the current one
	logic [CWP_W-1:0] save_win;
	logic [CWP_W-1:0] rest_win;

	// move targets an invalid window
	logic save_blk;
	logic rest_blk;

	// save goes down, wraps from 0 to the top
	assign save_win = (cwp == '0) ? LAST_WIN : cwp - 1'b1;

	// restore goes up, wraps from the top to 0
	assign rest_win = (cwp == LAST_WIN) ? '0 : cwp + 1'b1;

	// checked against the mask before any load this cycle
	assign save_blk = wim[save_win];
	assign rest_blk = wim[rest_win];

	// current window pointer and trap pulses
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			cwp <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else begin
			// pulses last one cycle
			overflow <= 1'b0;
			underflow <= 1'b0;
			if (save) begin
				// save wins over a restore in the same cycle
				if (save_blk) begin
					overflow <= 1'b1;
				end else begin
					cwp <= save_win;
				end
			end else if (restore) begin
				if (rest_blk) begin
					underflow <= 1'b1;
				end else begin
					cwp <= rest_win;
				end
			end
		end
	end

	// invalid mask, loaded whole
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			wim <= '0;
		end else if (wim_load) begin
			wim <= wim_data;
		end
	end

endmodule

/* design/access_arbiter.sv */
// Two-client register file arbiter

module access_arbiter (
	input logic Clk,
	input logic rst_n,
	input logic req_a,
	input logic req_b,
	input regwin_pkg::reg_access_t acc_a,
	input regwin_pkg::reg_access_t acc_b,
	input logic rd_valid,
	input logic [regwin_pkg::DATA_W-1:0] rd_data,
	output logic busy_a,
	output logic busy_b,
	output logic gnt_valid,
	output logic done_a,
	output logic done_b,
	output regwin_pkg::reg_access_t gnt_acc,
	output logic [regwin_pkg::DATA_W-1:0] rdata_a,
	output logic [regwin_pkg::DATA_W-1:0] rdata_b
);

	import regwin_pkg::*;

	// one pending slot per client
	logic pend_a_v;
	logic pend_b_v;
	reg_access_t pend_a;
	reg_access_t pend_b;

	// candidates this cycle, new strobe or held entry
	logic cand_a;
	logic cand_b;
	reg_access_t cand_acc_a;
	reg_access_t cand_acc_b;

	// 0 = a granted last, 1 = b granted last
	logic last_b;
	// grant goes to b this cycle
	logic sel_b;
	// loser of a tie, new strobe goes to its slot
	logic lose_a;
	logic lose_b;

	// grant id and direction, one cycle late to match rd_valid
	logic gnt_b_q;
	logic gnt_rd_q;

	// last read data per client
	logic [DATA_W-1:0] hold_a;
	logic [DATA_W-1:0] hold_b;

	// strobes while busy are dropped
	assign cand_a = pend_a_v || (req_a && !busy_a);
	assign cand_b = pend_b_v || (req_b && !busy_b);
	assign cand_acc_a = pend_a_v ? pend_a : acc_a;
	assign cand_acc_b = pend_b_v ? pend_b : acc_b;

	// round robin on a tie, otherwise whoever asked
	assign sel_b = (cand_a && cand_b) ? !last_b : cand_b;
	assign lose_a = cand_a && cand_b && sel_b;
	assign lose_b = cand_a && cand_b && !sel_b;

	assign gnt_valid = cand_a || cand_b;
	assign gnt_acc = sel_b ? cand_acc_b : cand_acc_a;

	// busy while the slot holds a request
	assign busy_a = pend_a_v;
	assign busy_b = pend_b_v;

	// pending flags and grant history
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_a_v <= 1'b0;
			pend_b_v <= 1'b0;
			// a counts as last granted, b wins the first tie
			last_b <= 1'b0;
			gnt_b_q <= 1'b0;
			gnt_rd_q <= 1'b0;
		end else begin
			// a held entry always wins the next cycle
			pend_a_v <= lose_a;
			pend_b_v <= lose_b;
			if (gnt_valid) begin
				last_b <= sel_b;
				gnt_b_q <= sel_b;
				gnt_rd_q <= !gnt_acc.rw;
			end
		end
	end

	// slot payload, only a new strobe can lose
	always_ff @(posedge Clk) begin
		if (lose_a) begin
			pend_a <= acc_a;
		end
		if (lose_b) begin
			pend_b <= acc_b;
		end
	end

	// done steered to the client of last cycle's grant
	assign done_a = rd_valid && !gnt_b_q;
	assign done_b = rd_valid && gnt_b_q;

	// fresh data in the done cycle, held value otherwise
	assign rdata_a = (done_a && gnt_rd_q) ? rd_data : hold_a;
	assign rdata_b = (done_b && gnt_rd_q) ? rd_data : hold_b;

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_a <= '0;
			hold_b <= '0;
		end else begin
			hold_a <= rdata_a;
			hold_b <= rdata_b;
		end
	end

endmodule

/* design/regwin_top.sv */
// Windowed register file top

module regwin_top #(
	parameter int NUM_WINDOWS = 4,
	localparam int CWP_W = $clog2(NUM_WINDOWS)
) (
	input logic Clk,
	input logic rst_n,

	// execute port
	input logic req_a,
	input regwin_pkg::reg_access_t acc_a,
	output logic busy_a,
	output logic done_a,
	output logic [regwin_pkg::DATA_W-1:0] rdata_a,

	// debug / host port
	input logic req_b,
	input regwin_pkg::reg_access_t acc_b,
	output logic busy_b,
	output logic done_b,
	output logic [regwin_pkg::DATA_W-1:0] rdata_b,

	// window control
	input logic save,
	input logic restore,
	input logic wim_load,
	input logic [NUM_WINDOWS-1:0] wim_data,
	output logic [CWP_W-1:0] cwp,
	output logic overflow,
	output logic underflow
);

	import regwin_pkg::*;

	// granted access, arbiter to register file
	logic gnt_valid;
	reg_access_t gnt_acc;

	// completion and read data back from the register file
	logic rd_valid;
	logic [DATA_W-1:0] rd_data;

	// picks one client access per cycle
	access_arbiter u_access_arbiter (
		.Clk(Clk),
		.rst_n(rst_n),
		.req_a(req_a),
		.req_b(req_b),
		.acc_a(acc_a),
		.acc_b(acc_b),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.busy_a(busy_a),
		.busy_b(busy_b),
		.gnt_valid(gnt_valid),
		.done_a(done_a),
		.done_b(done_b),
		.gnt_acc(gnt_acc),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	// save / restore and the invalid mask
	cwp_control #(
		.NUM_WINDOWS(NUM_WINDOWS)
	) u_cwp_control (
		.Clk(Clk),
		.rst_n(rst_n),
		.save(save),
		.restore(restore),
		.wim_load(wim_load),
		.wim_data(wim_data),
		.cwp(cwp),
		.overflow(overflow),
		.underflow(underflow)
	);

	// grants decode against the cwp of their own cycle
	register_file #(
		.NUM_WINDOWS(NUM_WINDOWS)
	) u_register_file (
		.Clk(Clk),
		.rst_n(rst_n),
		.gnt_valid(gnt_valid),
		.gnt_acc(gnt_acc),
		.cwp(cwp),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

/* testbench/regwin_tb.sv */
// Windowed register file testbench

module regwin_tb;

	import regwin_pkg::*;

	localparam int NW = 4;
	// globals plus 16 per window
	localparam int PHYS = 8 + 16 * NW;
	localparam int READS_PER_WIN = 6;
	localparam int N_SOLO = 200;
	localparam int N_ROUNDS = 4;
	localparam int MOVES_PER_ROUND = 15;
	localparam int N_MIXED = 150;
	// issued operations over all phases
	localparam int TOTAL_OPS = NW * (READS_PER_WIN + 1) + N_SOLO + 2 + (24 + NW * 8)
		+ (8 + N_ROUNDS * (MOVES_PER_ROUND + 1)) + N_MIXED + NW * 33;
	localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 100;

	logic Clk;
	logic rst_n;
	logic req_a, req_b;
	reg_access_t acc_a, acc_b;
	logic busy_a, busy_b;
	logic done_a, done_b;
	logic [DATA_W-1:0] rdata_a, rdata_b;
	logic save, restore, wim_load;
	logic [NW-1:0] wim_data;
	logic [$clog2(NW)-1:0] cwp;
	logic overflow, underflow;

	// reference model state
	logic [DATA_W-1:0] m_mem [PHYS];
	int m_cwp;
	logic [NW-1:0] m_wim;
	logic m_last_b;
	logic m_pend_a, m_pend_b;
	reg_access_t m_slot_a, m_slot_b;
	logic m_done_a, m_done_b, m_rd_a, m_rd_b, m_ovf, m_unf;
	// last read value each client should still show
	logic [DATA_W-1:0] hold_a, hold_b;
	logic [DATA_W-1:0] exp_a[$], exp_b[$];
	// cycle in which each accepted strobe was seen
	int wait_a[$], wait_b[$];
	int cycle;
	int busy_seen_a = 0;
	int busy_seen_b = 0;
	integer seed;

	regwin_top #(
		.NUM_WINDOWS(NW)
	) uut (
		.Clk(Clk),
		.rst_n(rst_n),
		.req_a(req_a),
		.acc_a(acc_a),
		.busy_a(busy_a),
		.done_a(done_a),
		.rdata_a(rdata_a),
		.req_b(req_b),
		.acc_b(acc_b),
		.busy_b(busy_b),
		.done_b(done_b),
		.rdata_b(rdata_b),
		.save(save),
		.restore(restore),
		.wim_load(wim_load),
		.wim_data(wim_data),
		.cwp(cwp),
		.overflow(overflow),
		.underflow(underflow)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	task automatic halt_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		halt_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
			halt_run();
		end
	endtask

	// visible register to physical slot with globals first
	function automatic int phys_index(input int win, input int r);
		if (r < 8) begin
			return r;
		end
		return 8 + ((16 * win + r - 8) % (16 * NW));
	endfunction

	// hot picks one of r8-r11 to force collisions
	function automatic reg_access_t random_access(input logic hot);
		reg_access_t acc;
		acc.rw = 1'($random(seed));
		acc.r_num = hot ? RNUM_W'(8 + $unsigned($random(seed)) % 4) : RNUM_W'($random(seed));
		acc.wdata = $random(seed);
		return acc;
	endfunction

	// cycle-level model updated at the edge that ends each cycle
	always @(posedge Clk or negedge rst_n) begin : ref_model
		logic cand_a;
		logic cand_b;
		logic sel_b;
		logic lose_a;
		logic lose_b;
		reg_access_t ga;
		int idx;
		int tgt;
		if (!rst_n) begin
			for (int i = 0; i < PHYS; i++) begin
				m_mem[i] = '0;
			end
			m_cwp = 0;
			m_wim = '0;
			// a counts as granted last
			m_last_b = 1'b0;
			m_pend_a = 1'b0;
			m_pend_b = 1'b0;
			m_done_a = 1'b0;
			m_done_b = 1'b0;
			m_rd_a = 1'b0;
			m_rd_b = 1'b0;
			m_ovf = 1'b0;
			m_unf = 1'b0;
			hold_a = '0;
			hold_b = '0;
			exp_a.delete();
			exp_b.delete();
			wait_a.delete();
			wait_b.delete();
			cycle = 0;
		end else begin
			cycle++;
			if (cycle > CYCLE_LIMIT) begin
				report_problem("timeout, the run went past its cycle limit");
			end
			if (req_a && !m_pend_a) begin
				wait_a.push_back(cycle);
			end
			if (req_b && !m_pend_b) begin
				wait_b.push_back(cycle);
			end
			cand_a = m_pend_a || req_a;
			cand_b = m_pend_b || req_b;
			// tie goes to whoever was not granted last
			sel_b = (cand_a && cand_b) ? !m_last_b : cand_b;
			ga = sel_b ? (m_pend_b ? m_slot_b : acc_b) : (m_pend_a ? m_slot_a : acc_a);
			m_done_a = cand_a && !sel_b;
			m_done_b = cand_b && sel_b;
			m_rd_a = m_done_a && !ga.rw;
			m_rd_b = m_done_b && !ga.rw;
			if (cand_a || cand_b) begin
				// decoded with the cwp of the grant cycle
				idx = phys_index(m_cwp, ga.r_num);
				if (ga.rw && idx != 0) begin
					m_mem[idx] = ga.wdata;
				end else if (!ga.rw && sel_b) begin
					exp_b.push_back(m_mem[idx]);
				end else if (!ga.rw) begin
					exp_a.push_back(m_mem[idx]);
				end
				m_last_b = sel_b;
			end
			lose_a = cand_a && cand_b && sel_b;
			lose_b = cand_a && cand_b && !sel_b;
			if (lose_a && !m_pend_a) begin
				m_slot_a = acc_a;
			end
			if (lose_b && !m_pend_b) begin
				m_slot_b = acc_b;
			end
			m_pend_a = lose_a;
			m_pend_b = lose_b;
			// window moves check the mask from before any load
			m_ovf = 1'b0;
			m_unf = 1'b0;
			if (save) begin
				tgt = (m_cwp + NW - 1) % NW;
				if (m_wim[tgt]) begin
					m_ovf = 1'b1;
				end else begin
					m_cwp = tgt;
				end
			end else if (restore) begin
				tgt = (m_cwp + 1) % NW;
				if (m_wim[tgt]) begin
					m_unf = 1'b1;
				end else begin
					m_cwp = tgt;
				end
			end
			if (wim_load) begin
				m_wim = wim_data;
			end
		end
	end

	// outputs settle well before the falling edge
	always @(negedge Clk) begin
		if (rst_n) begin
			// second cycle after a strobe is the last chance for done
			if (wait_a.size() != 0 && cycle - wait_a[0] >= 1 && !done_a) begin
				report_problem("client a got no done pulse within 2 cycles of its strobe");
			end
			if (wait_b.size() != 0 && cycle - wait_b[0] >= 1 && !done_b) begin
				report_problem("client b got no done pulse within 2 cycles of its strobe");
			end
			check_value("busy_a", busy_a, m_pend_a);
			check_value("busy_b", busy_b, m_pend_b);
			check_value("done_a", done_a, m_done_a);
			check_value("done_b", done_b, m_done_b);
			check_value("cwp", cwp, m_cwp);
			check_value("overflow", overflow, m_ovf);
			check_value("underflow", underflow, m_unf);
			if (done_a && wait_a.size() != 0) begin
				void'(wait_a.pop_front());
			end
			if (done_b && wait_b.size() != 0) begin
				void'(wait_b.pop_front());
			end
			if (m_rd_a) begin
				hold_a = exp_a.pop_front();
			end
			if (m_rd_b) begin
				hold_b = exp_b.pop_front();
			end
			// fresh data on a read done and the held value otherwise
			check_value("rdata_a", rdata_a, hold_a);
			check_value("rdata_b", rdata_b, hold_b);
			busy_seen_a += busy_a;
			busy_seen_b += busy_b;
		end
	end

	// advance to the next drive point and drop the strobes
	task automatic next_cycle();
		@(posedge Clk);
		#1;
		req_a = 1'b0;
		req_b = 1'b0;
		save = 1'b0;
		restore = 1'b0;
		wim_load = 1'b0;
	endtask

	// until every accepted strobe has seen its done
	task automatic wait_quiet();
		next_cycle();
		while (wait_a.size() != 0 || wait_b.size() != 0) begin
			next_cycle();
		end
	endtask

	task automatic access_a(input logic rw, input int r, input logic [DATA_W-1:0] data);
		req_a = 1'b1;
		acc_a.rw = rw;
		acc_a.r_num = RNUM_W'(r);
		acc_a.wdata = data;
		wait_quiet();
	endtask

	task automatic move_window(input logic do_save);
		save = do_save;
		restore = !do_save;
		wait_quiet();
	endtask

	initial begin : stimulus
		logic [DATA_W-1:0] vals [8];
		seed = 32'hbaf2_1708;
		rst_n = 1'b0;
		req_a = 1'b0;
		req_b = 1'b0;
		acc_a = '0;
		acc_b = '0;
		save = 1'b0;
		restore = 1'b0;
		wim_load = 1'b0;
		wim_data = '0;
		repeat (3) @(posedge Clk);
		#1;
		rst_n = 1'b1;

		// every window reads zero after reset
		for (int w = 0; w < NW; w++) begin
			for (int i = 0; i < READS_PER_WIN; i++) begin
				access_a(1'b0, $unsigned($random(seed)) % 32, '0);
			end
			move_window(1'b0);
		end

		// client a alone with window moves mixed in now and then
		for (int i = 0; i < N_SOLO; i++) begin
			if ($unsigned($random(seed)) % 8 == 0) begin
				save = 1'($random(seed));
				restore = !save;
			end
			req_a = 1'b1;
			acc_a = random_access(1'b0);
			wait_quiet();
		end
		access_a(1'b1, 0, 32'hffff_ffff);
		access_a(1'b0, 0, '0);
		check_value("rdata_a", rdata_a, '0);

		// outs of this window are the ins of the one below
		for (int i = 0; i < 8; i++) begin
			vals[i] = $random(seed);
			access_a(1'b1, 8 + i, vals[i]);
		end
		move_window(1'b1);
		for (int i = 0; i < 8; i++) begin
			access_a(1'b0, 24 + i, '0);
			check_value("rdata_a", rdata_a, vals[i]);
		end
		// globals look the same from every window
		for (int i = 1; i < 8; i++) begin
			vals[i] = $random(seed);
			access_a(1'b1, i, vals[i]);
		end
		for (int w = 0; w < NW; w++) begin
			for (int i = 1; i < 8; i++) begin
				access_a(1'b0, i, '0);
				check_value("rdata_a", rdata_a, vals[i]);
			end
			move_window(1'b0);
		end

		// blocked save and then a save beside a mask clear
		wim_load = 1'b1;
		wim_data = NW'(1) << ((m_cwp + NW - 1) % NW);
		wait_quiet();
		move_window(1'b1);
		save = 1'b1;
		wim_load = 1'b1;
		wim_data = '0;
		wait_quiet();
		wim_load = 1'b1;
		wim_data = NW'(1) << ((m_cwp + 1) % NW);
		wait_quiet();
		move_window(1'b0);
		wim_load = 1'b1;
		wim_data = '0;
		wait_quiet();
		// save beats restore
		save = 1'b1;
		restore = 1'b1;
		wait_quiet();
		for (int r = 0; r < N_ROUNDS; r++) begin
			wim_load = 1'b1;
			wim_data = NW'(1) << ($unsigned($random(seed)) % NW);
			wait_quiet();
			for (int i = 0; i < MOVES_PER_ROUND; i++) begin
				move_window(1'($random(seed)));
			end
		end
		wim_load = 1'b1;
		wim_data = '0;
		wait_quiet();

		// both clients back to back and only while not busy
		for (int i = 0; i < N_MIXED; i++) begin
			if (!busy_a && $unsigned($random(seed)) % 4 != 0) begin
				req_a = 1'b1;
				acc_a = random_access(1'($random(seed)));
			end
			if (!busy_b && $unsigned($random(seed)) % 4 != 0) begin
				req_b = 1'b1;
				acc_b = random_access(1'($random(seed)));
			end
			if ($unsigned($random(seed)) % 16 == 0) begin
				save = 1'($random(seed));
				restore = !save;
			end
			next_cycle();
		end
		wait_quiet();

		// final contents of every register in every window
		for (int w = 0; w < NW; w++) begin
			for (int r = 0; r < 32; r++) begin
				access_a(1'b0, r, '0);
			end
			move_window(1'b0);
		end

		if (busy_seen_a == 0 || busy_seen_b == 0) begin
			report_problem("busy never rose for one of the two clients");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

/* regwin.f */
design/regwin_pkg.sv
design/window_decoder.sv
design/register_file.sv
design/cwp_control.sv
design/access_arbiter.sv
design/regwin_top.sv
testbench/regwin_tb.sv
